// File: hdl/sram_geom_pkg.sv
// sram geometry package
// word, byte lane and address sizes shared by controller, banks and readback
package sram_geom_pkg;

   // data word and byte lanes
   localparam int DATA_W  = 32;
   localparam int WMASK_W = 4;

   // address sized for the deepest bank
   localparam int ADDR_W = 9;

   // two dual-port banks on the chip
   localparam int NUM_BANKS = 2;

   // bank 0 only decodes the low 8 address bits
   localparam int BANK0_DEPTH = 256;
   localparam int BANK1_DEPTH = 512;

endpackage

// File: hdl/sram_regs_pkg.sv
// sram test chip register map
// apb offsets, bit fields, opcodes and sequencer states
package sram_regs_pkg;

   // apb register offsets
   localparam logic [7:0] REG_CTRL   = 8'h00;
   localparam logic [7:0] REG_ADDR   = 8'h04;
   localparam logic [7:0] REG_WDATA  = 8'h08;
   localparam logic [7:0] REG_WMASK  = 8'h0C;
   localparam logic [7:0] REG_STATUS = 8'h10;
   localparam logic [7:0] REG_RDATA0 = 8'h14;
   localparam logic [7:0] REG_RDATA1 = 8'h18;

   // ctrl fields, opcode 1:0 and bank 5:4
   localparam int CTRL_OP_LSB   = 0;
   localparam int CTRL_BANK_LSB = 4;

   // addr fields, port 0 in 8:0 and port 1 in 24:16
   localparam int ADDR0_LSB = 0;
   localparam int ADDR1_LSB = 16;

   // status bits
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_DONE_BIT = 1;

   typedef enum logic [1:0] {
      OP_NOP   = 2'd0,
      OP_WRITE = 2'd1,
      OP_READ  = 2'd2
   } sram_op_e;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ISSUE   = 2'd1,
      ST_CAPTURE = 2'd2
   } ctrl_state_e;

endpackage

// File: hdl/sram_port_if.sv
// dual-port sram bank signals
// port 0 read/write with byte mask, port 1 read only
`timescale 1ns/1ps

interface sram_port_if
   import sram_geom_pkg::*;
();
   // port 0, chip select active low
   logic               csb0;
   logic               web0;
   logic [WMASK_W-1:0] wmask0;
   logic [ADDR_W-1:0]  addr0;
   logic [DATA_W-1:0]  din0;
   logic [DATA_W-1:0]  dout0;

   // port 1, read only
   logic               csb1;
   logic [ADDR_W-1:0]  addr1;
   logic [DATA_W-1:0]  dout1;

   modport ctrl (output csb0, web0, wmask0, addr0, din0, csb1, addr1);

   modport mem (input csb0, web0, wmask0, addr0, din0, csb1, addr1,
                output dout0, dout1);

   // capture side only sees read data
   modport mon (input dout0, dout1);

endinterface

// File: hdl/sram_dp_model.sv
// behavioral 1rw1r sram bank
// byte masked write on port 0, registered read data on both ports
`timescale 1ns/1ps

module sram_dp_model
   import sram_geom_pkg::*;
#(
   parameter int DEPTH = 256
) (
   input  logic      clk,
   sram_port_if.mem  mem
);

   // address bits actually decoded, upper bits alias
   localparam int AW = $clog2(DEPTH);

   logic [DATA_W-1:0] ram [DEPTH];
   logic [AW-1:0]     a0;
   logic [AW-1:0]     a1;

   assign a0 = mem.addr0[AW-1:0];
   assign a1 = mem.addr1[AW-1:0];

   // port 0 read/write
   always_ff @(posedge clk) begin
      if (!mem.csb0) begin
         if (!mem.web0) begin
            // only lanes with mask set, rest keep old bytes
            for (int i = 0; i < WMASK_W; i++) begin
               if (mem.wmask0[i]) begin
                  ram[a0][i*(DATA_W/WMASK_W) +: DATA_W/WMASK_W] <=
                     mem.din0[i*(DATA_W/WMASK_W) +: DATA_W/WMASK_W];
               end
            end
         end else begin
            mem.dout0 <= ram[a0];
         end
      end
   end

   // port 1 read, independent of port 0
   // same-address collision with a write returns the old word
   always_ff @(posedge clk) begin
      if (!mem.csb1) begin
         mem.dout1 <= ram[a1];
      end
   end

endmodule

// File: hdl/sram_tc_ctrl.sv
// sram test chip controller
// apb slave, config registers and the issue/capture sequencer for both banks
`timescale 1ns/1ps

module sram_tc_ctrl
   import sram_geom_pkg::*, sram_regs_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  logic [7:0]        paddr_i,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [DATA_W-1:0] pwdata_i,
   input  logic [DATA_W-1:0] rdata0_i,
   input  logic [DATA_W-1:0] rdata1_i,
   output logic [DATA_W-1:0] prdata_o,
   output logic              pready_o,
   output logic              pslverr_o,
   output logic              irq_o,
   output logic              capture_o,
   output logic              bank_o,
   sram_port_if.ctrl         bank0,
   sram_port_if.ctrl         bank1
);

   ctrl_state_e        state_q;
   sram_op_e           op_q;
   logic               bank_q;
   logic [ADDR_W-1:0]  addr0_q;
   logic [ADDR_W-1:0]  addr1_q;
   logic [DATA_W-1:0]  wdata_q;
   logic [WMASK_W-1:0] wmask_q;
   logic               done_q;
   logic               busy;
   logic               apb_acc;
   logic               mapped;
   logic               cfg_reg;
   logic               bad_ctrl;
   logic               err;
   logic               wr_ok;
   logic               ctrl_go;
   logic               status_rd;
   logic               issue;
   sram_op_e           wr_op;
   logic [1:0]         wr_bank;

   // no wait states
   assign pready_o = 1'b1;
   assign apb_acc  = psel_i & penable_i;
   assign busy     = (state_q != ST_IDLE);

   // ctrl fields of the incoming write
   assign wr_op   = sram_op_e'(pwdata_i[CTRL_OP_LSB +: 2]);
   assign wr_bank = pwdata_i[CTRL_BANK_LSB +: 2];

   // offset decode
   always_comb begin
      mapped  = 1'b1;
      cfg_reg = 1'b0;
      case (paddr_i)
         REG_CTRL, REG_ADDR, REG_WDATA, REG_WMASK: cfg_reg = 1'b1;
         REG_STATUS, REG_RDATA0, REG_RDATA1:       mapped = 1'b1;
         default:                                  mapped = 1'b0;
      endcase
   end

   // error rules, an erroring access changes nothing
   assign bad_ctrl  = (paddr_i == REG_CTRL) && ((wr_bank >= NUM_BANKS) || (wr_op == OP_NOP));
   assign err       = !mapped || (pwrite_i && ((cfg_reg && busy) || bad_ctrl));
   assign pslverr_o = apb_acc & err;

   assign wr_ok     = apb_acc & pwrite_i & ~err;
   assign ctrl_go   = wr_ok & (paddr_i == REG_CTRL);
   assign status_rd = apb_acc & ~pwrite_i & (paddr_i == REG_STATUS);

   // config registers
   always_ff @(posedge clk) begin
      if (!resetn) begin
         op_q    <= OP_NOP;
         bank_q  <= 1'b0;
         addr0_q <= '0;
         addr1_q <= '0;
         wdata_q <= '0;
         wmask_q <= '0;
      end else if (wr_ok) begin
         case (paddr_i)
            REG_CTRL: begin
               op_q   <= wr_op;
               bank_q <= wr_bank[0];
            end
            REG_ADDR: begin
               addr0_q <= pwdata_i[ADDR0_LSB +: ADDR_W];
               addr1_q <= pwdata_i[ADDR1_LSB +: ADDR_W];
            end
            REG_WDATA: wdata_q <= pwdata_i;
            REG_WMASK: wmask_q <= pwdata_i[WMASK_W-1:0];
            default:   ;
         endcase
      end
   end

   // sequencer, idle -> issue (cs low one cycle) -> capture -> idle
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= ST_IDLE;
         done_q  <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE:    if (ctrl_go) state_q <= ST_ISSUE;
            ST_ISSUE:   state_q <= ST_CAPTURE;
            ST_CAPTURE: state_q <= ST_IDLE;
            default:    state_q <= ST_IDLE;
         endcase
         // status read clears done, a finishing op wins
         if (status_rd) done_q <= 1'b0;
         if (state_q == ST_CAPTURE) done_q <= 1'b1;
      end
   end

   assign issue     = (state_q == ST_ISSUE);
   assign capture_o = (state_q == ST_CAPTURE);
   assign bank_o    = bank_q;
   assign irq_o     = done_q;

   // only the chosen bank sees its selects, port 1 only on reads
   assign bank0.csb0   = ~(issue & ~bank_q);
   assign bank0.csb1   = ~(issue & ~bank_q & (op_q == OP_READ));
   assign bank0.web0   = (op_q != OP_WRITE);
   assign bank0.wmask0 = wmask_q;
   assign bank0.addr0  = addr0_q;
   assign bank0.din0   = wdata_q;
   assign bank0.addr1  = addr1_q;

   assign bank1.csb0   = ~(issue & bank_q);
   assign bank1.csb1   = ~(issue & bank_q & (op_q == OP_READ));
   assign bank1.web0   = (op_q != OP_WRITE);
   assign bank1.wmask0 = wmask_q;
   assign bank1.addr0  = addr0_q;
   assign bank1.din0   = wdata_q;
   assign bank1.addr1  = addr1_q;

   // read mux
   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         REG_CTRL: begin
            prdata_o[CTRL_OP_LSB +: 2] = op_q;
            prdata_o[CTRL_BANK_LSB]    = bank_q;
         end
         REG_ADDR: begin
            prdata_o[ADDR0_LSB +: ADDR_W] = addr0_q;
            prdata_o[ADDR1_LSB +: ADDR_W] = addr1_q;
         end
         REG_WDATA:  prdata_o = wdata_q;
         REG_WMASK:  prdata_o[WMASK_W-1:0] = wmask_q;
         REG_STATUS: begin
            prdata_o[STAT_BUSY_BIT] = busy;
            prdata_o[STAT_DONE_BIT] = done_q;
         end
         REG_RDATA0: prdata_o = rdata0_i;
         REG_RDATA1: prdata_o = rdata1_i;
         default:    prdata_o = '0;
      endcase
   end

endmodule

// File: hdl/sram_readback.sv
// sram readback capture
// holds both port outputs of the selected bank after each operation
`timescale 1ns/1ps

module sram_readback
   import sram_geom_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  logic              capture_i,
   input  logic              bank_i,
   sram_port_if.mon          bank0,
   sram_port_if.mon          bank1,
   output logic [DATA_W-1:0] rdata0_o,
   output logic [DATA_W-1:0] rdata1_o
);

   logic [DATA_W-1:0] sel_dout0;
   logic [DATA_W-1:0] sel_dout1;

   // pick the bank that ran the op
   assign sel_dout0 = bank_i ? bank1.dout0 : bank0.dout0;
   assign sel_dout1 = bank_i ? bank1.dout1 : bank0.dout1;

   // load on the capture strobe, hold otherwise
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rdata0_o <= '0;
         rdata1_o <= '0;
      end else if (capture_i) begin
         rdata0_o <= sel_dout0;
         rdata1_o <= sel_dout1;
      end
   end

endmodule

// File: hdl/sram_tc_top.sv
// sram test chip top
// apb controller, two dual-port banks and the readback capture
`timescale 1ns/1ps

module sram_tc_top
   import sram_geom_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  logic [7:0]        paddr_i,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [DATA_W-1:0] pwdata_i,
   output logic [DATA_W-1:0] prdata_o,
   output logic              pready_o,
   output logic              pslverr_o,
   output logic              irq_o
);

   logic              capture;
   logic              bank_sel;
   logic [DATA_W-1:0] rdata0;
   logic [DATA_W-1:0] rdata1;

   // one port bundle per bank
   sram_port_if bank0_if ();
   sram_port_if bank1_if ();

   sram_tc_ctrl sram_tc_ctrl_inst (
      .clk       (clk),
      .resetn    (resetn),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .rdata0_i  (rdata0),
      .rdata1_i  (rdata1),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .irq_o     (irq_o),
      .capture_o (capture),
      .bank_o    (bank_sel),
      .bank0     (bank0_if.ctrl),
      .bank1     (bank1_if.ctrl)
   );

   // bank 0, 256 words
   sram_dp_model #(.DEPTH(BANK0_DEPTH)) bank0_inst (
      .clk (clk),
      .mem (bank0_if.mem)
   );

   // bank 1, 512 words
   sram_dp_model #(.DEPTH(BANK1_DEPTH)) bank1_inst (
      .clk (clk),
      .mem (bank1_if.mem)
   );

   sram_readback sram_readback_inst (
      .clk       (clk),
      .resetn    (resetn),
      .capture_i (capture),
      .bank_i    (bank_sel),
      .bank0     (bank0_if.mon),
      .bank1     (bank1_if.mon),
      .rdata0_o  (rdata0),
      .rdata1_o  (rdata1)
   );

endmodule

// File: sim/sram_tc_sva.sv
// apb protocol checks on the sram test chip top
// bound into the top level
`timescale 1ns/1ps

module sram_tc_sva (
   input logic clk,
   input logic resetn,
   input logic psel_i,
   input logic penable_i,
   input logic pready_o,
   input logic pslverr_o,
   input logic irq_o
);

   // count of failed assertions
   int unsigned fail_count = 0;

   // zero wait states out of reset
   a_pready_high: assert property (@(posedge clk) resetn |-> pready_o)
      else begin
         $error("pready_o low while out of reset");
         fail_count++;
      end

   // error response only in an access phase
   a_pslverr_access: assert property (@(posedge clk) pslverr_o |-> (psel_i && penable_i))
      else begin
         $error("pslverr_o high outside an access phase");
         fail_count++;
      end

   // sampled mid cycle, after the synchronous reset has cleared done
   a_irq_reset: assert property (@(negedge clk) !resetn |-> !irq_o)
      else begin
         $error("irq_o high during reset");
         fail_count++;
      end

endmodule

bind sram_tc_top sram_tc_sva sram_tc_sva_inst (
   .clk       (clk),
   .resetn    (resetn),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_o  (pready_o),
   .pslverr_o (pslverr_o),
   .irq_o     (irq_o)
);

// File: sim/sram_tc_tb.sv
// sram test chip testbench
// apb driven directed tests against a shadow model of both banks
`timescale 1ns/1ps

module sram_tc_tb
   import sram_geom_pkg::*, sram_regs_pkg::*;
();

   logic              clk;
   logic              resetn;
   logic [7:0]        paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              irq;
   logic [31:0]       seed;

   // expected memory contents per bank
   logic [DATA_W-1:0] shadow0 [BANK0_DEPTH];
   logic [DATA_W-1:0] shadow1 [BANK1_DEPTH];

   sram_tc_top sram_tc_top_inst (
      .clk       (clk),
      .resetn    (resetn),
      .paddr_i   (paddr),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr),
      .irq_o     (irq)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "stopping on first error");
   endtask

   // protocol checker bound into the dut
   always @(sram_tc_top_inst.sram_tc_sva_inst.fail_count) begin
      if (sram_tc_top_inst.sram_tc_sva_inst.fail_count != 0) begin
         fail_stop("A protocol assertion on the DUT failed");
      end
   end

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_stop($sformatf("Mismatch at %0d ns: %s got 0x%08h expected 0x%08h",
                             $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // one transfer, called on a falling edge and returns on one with the bus idle
   task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                           input logic exp_err, output logic [31:0] rdata);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      // access phase settled, completes on the next rising edge
      #1;
      check_eq("pready_o", pready, 1'b1);
      check_eq("pslverr_o", pslverr, exp_err);
      rdata = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] unused;
      apb_xfer(addr, 1'b1, data, exp_err, unused);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
      apb_xfer(addr, 1'b0, 32'h0, exp_err, data);
   endtask

   // poll status until done, reading it also clears done
   task automatic wait_done();
      logic [31:0] st;
      int          polls;
      polls = 0;
      st    = '0;
      while (st[STAT_DONE_BIT] !== 1'b1) begin
         if (polls == 20) fail_stop("Timed out waiting for the memory operation to finish");
         apb_read(REG_STATUS, st, 1'b0);
         polls++;
      end
      check_eq("status", st, 32'h2);
   endtask

   function automatic logic [31:0] ctrl_word(input sram_op_e op, input logic [1:0] bank);
      return (32'(bank) << 4) | 32'(op);
   endfunction

   // bank 0 decodes only 8 address bits
   function automatic logic [31:0] shadow_get(input logic bank, input logic [8:0] addr);
      return bank ? shadow1[addr] : shadow0[addr[7:0]];
   endfunction

   task automatic sram_write(input logic bank, input logic [8:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
      logic [31:0] word;
      apb_write(REG_ADDR, {23'b0, addr}, 1'b0);
      apb_write(REG_WDATA, data, 1'b0);
      apb_write(REG_WMASK, {28'b0, mask}, 1'b0);
      apb_write(REG_CTRL, ctrl_word(OP_WRITE, {1'b0, bank}), 1'b0);
      wait_done();
      // masked lanes take new bytes, the rest keep old ones
      word = shadow_get(bank, addr);
      for (int i = 0; i < 4; i++) begin
         if (mask[i]) word[i*8 +: 8] = data[i*8 +: 8];
      end
      if (bank) shadow1[addr] = word;
      else shadow0[addr[7:0]] = word;
   endtask

   task automatic sram_read(input logic bank, input logic [8:0] a0, input logic [8:0] a1);
      logic [31:0] rd;
      apb_write(REG_ADDR, {7'b0, a1, 7'b0, a0}, 1'b0);
      apb_write(REG_CTRL, ctrl_word(OP_READ, {1'b0, bank}), 1'b0);
      wait_done();
      apb_read(REG_RDATA0, rd, 1'b0);
      check_eq("rdata0", rd, shadow_get(bank, a0));
      apb_read(REG_RDATA1, rd, 1'b0);
      check_eq("rdata1", rd, shadow_get(bank, a1));
   endtask

   task automatic test_reset_values();
      logic [31:0] rd;
      check_eq("irq_o", irq, 1'b0);
      apb_read(REG_STATUS, rd, 1'b0);
      check_eq("status", rd, 32'h0);
      apb_read(REG_RDATA0, rd, 1'b0);
      check_eq("rdata0", rd, 32'h0);
      apb_read(REG_RDATA1, rd, 1'b0);
      check_eq("rdata1", rd, 32'h0);
   endtask

   task automatic test_full_writes();
      logic [8:0] a;
      for (int i = 0; i < 4; i++) begin
         seed = xorshift32(seed);
         a    = {1'b0, seed[7:0]};
         seed = xorshift32(seed);
         sram_write(1'b0, a, seed, 4'hF);
         seed = xorshift32(seed);
         sram_write(1'b1, a, seed, 4'hF);
         // upper half of bank 1 must not alias onto the lower half
         seed = xorshift32(seed);
         sram_write(1'b1, a | 9'h100, seed, 4'hF);
         sram_read(1'b0, a, a);
         sram_read(1'b1, a, a);
         sram_read(1'b1, a | 9'h100, a | 9'h100);
      end
   endtask

   task automatic test_partial_masks();
      sram_write(1'b1, 9'h1a0, 32'h1122_3344, 4'hF);
      sram_write(1'b1, 9'h033, 32'h5566_7788, 4'hF);
      sram_write(1'b1, 9'h1a0, 32'haabb_ccdd, 4'b0101);
      sram_read(1'b1, 9'h1a0, 9'h033);
      seed = xorshift32(seed);
      sram_write(1'b0, 9'h040, seed, 4'hF);
      seed = xorshift32(seed);
      sram_write(1'b0, 9'h041, seed, 4'hF);
      seed = xorshift32(seed);
      sram_write(1'b0, 9'h040, seed, 4'b1000);
      sram_read(1'b0, 9'h041, 9'h040);
   endtask

   task automatic test_status_irq();
      logic [31:0] rd;
      apb_write(REG_ADDR, 32'h0041_0040, 1'b0);
      apb_write(REG_CTRL, ctrl_word(OP_READ, 2'd0), 1'b0);
      // back to back read lands in the capture cycle
      apb_read(REG_STATUS, rd, 1'b0);
      check_eq("status", rd, 32'h1);
      check_eq("irq_o", irq, 1'b1);
      apb_read(REG_STATUS, rd, 1'b0);
      check_eq("status", rd, 32'h2);
      check_eq("irq_o", irq, 1'b0);
      apb_read(REG_STATUS, rd, 1'b0);
      check_eq("status", rd, 32'h0);
      apb_read(REG_RDATA0, rd, 1'b0);
      check_eq("rdata0", rd, shadow_get(1'b0, 9'h040));
   endtask

   task automatic test_error_responses();
      logic [31:0] rd;
      seed = xorshift32(seed);
      sram_write(1'b0, 9'h077, seed, 4'hF);
      apb_write(REG_WDATA, ~seed, 1'b0);
      apb_write(8'h1C, 32'hdead_beef, 1'b1);
      apb_read(8'h40, rd, 1'b1);
      apb_write(REG_CTRL, ctrl_word(OP_WRITE, 2'd2), 1'b1);
      apb_write(REG_CTRL, ctrl_word(OP_NOP, 2'd0), 1'b1);
      apb_read(REG_CTRL, rd, 1'b0);
      check_eq("ctrl register", rd, ctrl_word(OP_WRITE, 2'd0));
      apb_read(REG_STATUS, rd, 1'b0);
      check_eq("status", rd, 32'h0);
      // address write during the running op is refused
      apb_write(REG_CTRL, ctrl_word(OP_READ, 2'd0), 1'b0);
      apb_write(REG_ADDR, 32'h0001_0001, 1'b1);
      wait_done();
      apb_read(REG_ADDR, rd, 1'b0);
      check_eq("addr register", rd, 32'h0000_0077);
      apb_read(REG_RDATA0, rd, 1'b0);
      check_eq("rdata0", rd, shadow_get(1'b0, 9'h077));
   endtask

   task automatic test_bank0_alias();
      seed = xorshift32(seed);
      sram_write(1'b0, 9'h105, seed, 4'hF);
      sram_read(1'b0, 9'h005, 9'h105);
   endtask

   initial begin
      clk     = 1'b0;
      resetn  = 1'b0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      seed    = 32'h403a_aae9;
      repeat (2) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
      test_reset_values();
      test_full_writes();
      test_partial_masks();
      test_status_irq();
      test_error_responses();
      test_bank0_alias();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: sram_tc.f
hdl/sram_geom_pkg.sv
hdl/sram_regs_pkg.sv
hdl/sram_port_if.sv
hdl/sram_dp_model.sv
hdl/sram_tc_ctrl.sv
hdl/sram_readback.sv
hdl/sram_tc_top.sv
sim/sram_tc_sva.sv
sim/sram_tc_tb.sv
